/* verilog.f */
design/regFilePkg.sv
design/writeBackAligner.sv
design/generalRegFile.sv
design/apbRegInspector.sv
design/regFileUnit.sv
test/regFileUnit_assertions.sv
test/regFileUnitTb.sv

/* Makefile */
# Verilator simulation of the register file unit.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= regFileUnitTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= Simulation passed

.PHONY: sim clean

# Build and run; the status comes from the search for the pass line.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* test/regFileUnitTb.sv */
`timescale 1ns/100ps

module regFileUnitTb;

	import regFilePkg::*;

	// About 2050 cycles of tests, with margin.
	localparam int MaxCycles = 3000;
	localparam int ApbMaxWait = 4;

	logic       Clk;
	logic       reset;
	logic       WbValid;
	regAddrT    WbAddr;
	accessSizeT WbSize;
	logic [1:0] WbOffset;
	regDataT    WbData;
	regAddrT    ReadAddr [NumReadPorts];
	regDataT    ReadData [NumReadPorts];
	logic       PSEL;
	logic       PENABLE;
	logic       PWRITE;
	apbAddrT    PADDR;
	regDataT    PRDATA;
	logic       PREADY;
	logic       PSLVERR;

	int       seed = 32'h4fed;
	int       cycleCount = 0;
	string    testName = "reset";

	// Shadow of the storage and of the staged write-back.
	regDataT  shadow [NumRegs];
	regAddrT  stagedAddr;
	laneMaskT stagedLanes;
	regDataT  stagedData;

	logic     apbSetupSeen;
	logic     apbExpErr;
	regDataT  apbExpData;

	regFileUnit i_regFileUnit (
		.Clk      (Clk),
		.reset    (reset),
		.WbValid  (WbValid),
		.WbAddr   (WbAddr),
		.WbSize   (WbSize),
		.WbOffset (WbOffset),
		.WbData   (WbData),
		.ReadAddr (ReadAddr),
		.ReadData (ReadData),
		.PSEL     (PSEL),
		.PENABLE  (PENABLE),
		.PWRITE   (PWRITE),
		.PADDR    (PADDR),
		.PRDATA   (PRDATA),
		.PREADY   (PREADY),
		.PSLVERR  (PSLVERR)
	);

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	// **********************************************************************
	// Reference model.
	// **********************************************************************

	function automatic laneMaskT laneEnables(input accessSizeT size, input logic [1:0] offset);
		laneMaskT lanes;
		lanes = '0;
		for (int k = 0; k < 4; k++) begin
			case (size)
				SizeByte: lanes[k] = (k == int'(offset));
				SizeHalf: lanes[k] = ((k / 2) == int'(offset[1]));
				SizeWord: lanes[k] = 1'b1;
				default:  lanes[k] = 1'b0;
			endcase
		end
		return lanes;
	endfunction

	function automatic regDataT alignedData(input accessSizeT size, input regDataT data);
		if (size == SizeByte) begin
			return {data[7:0], data[7:0], data[7:0], data[7:0]};
		end else if (size == SizeHalf) begin
			return {data[15:0], data[15:0]};
		end
		return data;
	endfunction

	function automatic regDataT expectedRead(input regAddrT addr);
		regDataT value;
		value = shadow[addr];
		if (addr == stagedAddr) begin
			for (int k = 0; k < 4; k++) begin
				if (stagedLanes[k]) begin
					value[8*k +: 8] = stagedData[8*k +: 8];
				end
			end
		end
		if (addr == '0) begin
			value = '0;
		end
		return value;
	endfunction

	always @(posedge Clk) begin
		if (reset) begin
			for (int i = 0; i < NumRegs; i++) begin
				shadow[i] = '0;
			end
			stagedLanes = '0;
		end else begin
			shadow[stagedAddr] = expectedRead(stagedAddr);
			stagedAddr = WbAddr;
			stagedLanes = WbValid ? laneEnables(WbSize, WbOffset) : '0;
			stagedData = alignedData(WbSize, WbData);
		end
	end

	// **********************************************************************
	// Checking.
	// **********************************************************************

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s, %s: expected %h, actual %h", testName, what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Stopping at the first mismatch.");
		end
	endtask

	always @(negedge Clk) begin
		if (reset !== 1'b0) begin
			apbSetupSeen = 1'b0;
			apbExpErr = 1'b0;
			apbExpData = '0;
		end else begin
			for (int p = 0; p < NumReadPorts; p++) begin
				checkValue($sformatf("read port %0d", p), expectedRead(ReadAddr[p]), ReadData[p]);
			end
			checkValue("PREADY", 32'(apbSetupSeen), 32'(PREADY));
			checkValue("PSLVERR", 32'(apbSetupSeen && apbExpErr), 32'(PSLVERR));
			checkValue("PRDATA", apbExpData, PRDATA);
			// Setup phase, so the next cycle is the access phase.
			if (PSEL && !PENABLE) begin
				apbExpErr = PWRITE;
				if (!PWRITE) begin
					apbExpData = expectedRead(PADDR[6:2]);
				end
			end
			apbSetupSeen = PSEL && !PENABLE;
		end
	end

	always @(posedge Clk) begin
		cycleCount++;
		if (cycleCount >= MaxCycles) begin
			$display("Timeout: the run did not finish within %0d cycles.", MaxCycles);
			$display("Simulation failed");
			$fatal(1, "Cycle limit reached.");
		end
	end

	// **********************************************************************
	// Stimulus.
	// **********************************************************************

	function automatic logic [31:0] randWord();
		return $random(seed);
	endfunction

	function automatic regAddrT randReg();
		logic [31:0] r;
		r = randWord();
		return r[4:0];
	endfunction

	task automatic driveWb(input logic valid, input regAddrT addr, input accessSizeT size,
		input logic [1:0] offset, input regDataT data);
		@(posedge Clk);
		WbValid <= valid;
		WbAddr <= addr;
		WbSize <= size;
		WbOffset <= offset;
		WbData <= data;
	endtask

	task automatic setReadAll(input regAddrT addr);
		for (int p = 0; p < NumReadPorts; p++) begin
			ReadAddr[p] <= addr;
		end
	endtask

	task automatic setReadRandom();
		for (int p = 0; p < NumReadPorts; p++) begin
			ReadAddr[p] <= randReg();
		end
	endtask

	task automatic apbTransfer(input logic write, input apbAddrT addr);
		int waits;
		@(posedge Clk);
		PSEL <= 1'b1;
		PENABLE <= 1'b0;
		PWRITE <= write;
		PADDR <= addr;
		@(posedge Clk);
		PENABLE <= 1'b1;
		waits = 0;
		@(negedge Clk);
		while (!PREADY) begin
			waits++;
			if (waits > ApbMaxWait) begin
				$display("APB transfer to %h never saw PREADY.", addr);
				$display("Simulation failed");
				$fatal(1, "APB transfer hung.");
			end
			@(negedge Clk);
		end
		@(posedge Clk);
		PSEL <= 1'b0;
		PENABLE <= 1'b0;
		PWRITE <= 1'b0;
	endtask

	function automatic apbAddrT randApbAddr(input regAddrT reg_);
		logic [31:0] r;
		r = randWord();
		return {r[7], reg_, r[1:0]};
	endfunction

	initial begin
		logic [31:0] r;
		regAddrT     target;
		int          assertionFailures;
		reset = 1'b1;
		// A write-back held during reset must be dropped.
		WbValid = 1'b1;
		WbAddr = 5'd1;
		WbSize = SizeWord;
		WbOffset = '0;
		WbData = '1;
		for (int p = 0; p < NumReadPorts; p++) begin
			ReadAddr[p] = '0;
		end
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		repeat (5) @(posedge Clk);
		reset <= 1'b0;
		WbValid <= 1'b0;

		testName = "reset values";
		for (int a = 0; a < NumRegs; a++) begin
			@(posedge Clk);
			setReadAll(regAddrT'(a));
		end
		for (int a = 0; a < NumRegs; a++) begin
			apbTransfer(1'b0, randApbAddr(regAddrT'(a)));
		end

		testName = "random words";
		for (int n = 0; n < 400; n++) begin
			r = randWord();
			target = (n % 16 == 0) ? regAddrT'(0) : randReg();
			driveWb(r[0] | r[1], target, SizeWord, r[3:2], randWord());
			setReadRandom();
			ReadAddr[0] <= (n % 8 == 0) ? regAddrT'(0) : randReg();
		end

		testName = "byte and half lanes";
		foreach (shadow[i]) begin
			if (i % 7 == 1) begin
				driveWb(1'b1, regAddrT'(i), SizeWord, 2'd0, randWord());
				for (int off = 0; off < 8; off++) begin
					driveWb(1'b1, regAddrT'(i), (off < 4) ? SizeByte : SizeHalf,
						off[1:0], randWord());
					driveWb(1'b0, '0, SizeWord, 2'd0, '0);
					setReadAll(regAddrT'(i));
				end
			end
		end
		for (int n = 0; n < 400; n++) begin
			r = randWord();
			driveWb(r[0] | r[1], randReg(), accessSizeT'(r[31:8] % 24'd3), r[3:2], randWord());
			setReadRandom();
		end

		testName = "bypass";
		for (int n = 0; n < 100; n++) begin
			r = randWord();
			target = randReg();
			driveWb(1'b1, target, accessSizeT'(r[31:8] % 24'd3), r[3:2], randWord());
			driveWb(1'b0, '0, SizeWord, 2'd0, '0);
			setReadAll(target);
		end

		testName = "apb reads";
		for (int n = 0; n < 200; n++) begin
			r = randWord();
			target = randReg();
			driveWb(r[0], target, accessSizeT'(r[31:8] % 24'd3), r[3:2], randWord());
			setReadRandom();
			apbTransfer(1'b0, randApbAddr(r[4] ? target : randReg()));
		end

		testName = "apb writes";
		driveWb(1'b0, '0, SizeWord, 2'd0, '0);
		for (int n = 0; n < 10; n++) begin
			target = randReg();
			setReadAll(target);
			apbTransfer(1'b1, randApbAddr(target));
		end

		repeat (4) @(posedge Clk);
		assertionFailures = i_regFileUnit.i_apbRegInspector.i_apbChecks.failCount
			+ i_regFileUnit.i_generalRegFile.i_laneChecks.failCount;
		if (assertionFailures == 0) begin
			$display("Simulation passed");
		end else begin
			$display("The bound assertions failed %0d times.", assertionFailures);
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* test/regFileUnit_assertions.sv */
`timescale 1ns/100ps

module regFileUnit_assertions #(
	parameter bit CheckApb   = 1'b0,
	parameter bit CheckLanes = 1'b0
) (
	input logic                  Clk,
	input logic                  reset,
	input logic                  PSEL,
	input logic                  PENABLE,
	input logic                  PWRITE,
	input logic                  PREADY,
	input logic                  PSLVERR,
	input regFilePkg::laneMaskT  WriteLanes
);

	int failCount = 0;

	// **********************************************************************
	// APB slave protocol.
	// **********************************************************************

	if (CheckApb) begin : apbChecks
		readyInAccess: assert property (@(posedge Clk) disable iff (reset)
			PREADY |-> (PSEL && PENABLE))
			else begin
				$error("PREADY high outside an APB access phase.");
				failCount++;
			end

		errorOnWrite: assert property (@(posedge Clk) disable iff (reset)
			PSLVERR |-> (PWRITE && PREADY))
			else begin
				$error("PSLVERR high on a transfer that is not a write.");
				failCount++;
			end

		quietAfterReset: assert property (@(posedge Clk)
			$past(reset) |-> (!PREADY && !PSLVERR))
			else begin
				$error("APB response active right after reset.");
				failCount++;
			end
	end

	// Lane enables from the write-back stage.
	if (CheckLanes) begin : laneChecks
		noWriteAfterReset: assert property (@(posedge Clk)
			$past(reset) |-> (WriteLanes == '0))
			else begin
				$error("Lanes written in the cycle after reset.");
				failCount++;
			end
	end

endmodule

bind apbRegInspector regFileUnit_assertions #(.CheckApb(1'b1)) i_apbChecks (
	.Clk        (Clk),
	.reset      (reset),
	.PSEL       (PSEL),
	.PENABLE    (PENABLE),
	.PWRITE     (PWRITE),
	.PREADY     (PREADY),
	.PSLVERR    (PSLVERR),
	.WriteLanes (4'b0000)
);

bind generalRegFile regFileUnit_assertions #(.CheckLanes(1'b1)) i_laneChecks (
	.Clk        (Clk),
	.reset      (reset),
	.PSEL       (1'b0),
	.PENABLE    (1'b0),
	.PWRITE     (1'b0),
	.PREADY     (1'b0),
	.PSLVERR    (1'b0),
	.WriteLanes (WriteLanes)
);

/* design/regFileUnit.sv */
`timescale 1ns/100ps

module regFileUnit (
	input  logic                    Clk,
	input  logic                    reset,

	// Write-back, sampled on every edge.
	input  logic                    WbValid,
	input  regFilePkg::regAddrT     WbAddr,
	input  regFilePkg::accessSizeT  WbSize,
	input  logic [1:0]              WbOffset,
	input  regFilePkg::regDataT     WbData,

	// Pipeline read ports.
	input  regFilePkg::regAddrT     ReadAddr [regFilePkg::NumReadPorts],
	output regFilePkg::regDataT     ReadData [regFilePkg::NumReadPorts],

	// Debug APB.
	input  logic                    PSEL,
	input  logic                    PENABLE,
	input  logic                    PWRITE,
	input  regFilePkg::apbAddrT     PADDR,
	output regFilePkg::regDataT     PRDATA,
	output logic                    PREADY,
	output logic                    PSLVERR
);

	import regFilePkg::*;

	regAddrT  writeAddr;
	laneMaskT writeLanes;
	regDataT  writeData;

	regAddrT  inspectAddr;
	regDataT  inspectData;

	// **********************************************************************
	// Write-back stage, storage and debug port.
	// **********************************************************************

	writeBackAligner i_writeBackAligner (
		.Clk        (Clk),
		.reset      (reset),
		.WbValid    (WbValid),
		.WbAddr     (WbAddr),
		.WbSize     (WbSize),
		.WbOffset   (WbOffset),
		.WbData     (WbData),
		.WriteAddr  (writeAddr),
		.WriteLanes (writeLanes),
		.WriteData  (writeData)
	);

	generalRegFile i_generalRegFile (
		.Clk         (Clk),
		.reset       (reset),
		.WriteAddr   (writeAddr),
		.WriteLanes  (writeLanes),
		.WriteData   (writeData),
		.ReadAddr    (ReadAddr),
		.ReadData    (ReadData),
		.InspectAddr (inspectAddr),
		.InspectData (inspectData)
	);

	apbRegInspector i_apbRegInspector (
		.Clk         (Clk),
		.reset       (reset),
		.PSEL        (PSEL),
		.PENABLE     (PENABLE),
		.PWRITE      (PWRITE),
		.PADDR       (PADDR),
		.PRDATA      (PRDATA),
		.PREADY      (PREADY),
		.PSLVERR     (PSLVERR),
		.InspectAddr (inspectAddr),
		.InspectData (inspectData)
	);

endmodule

/* design/apbRegInspector.sv */
`timescale 1ns/100ps

module apbRegInspector (
	input  logic                 Clk,
	input  logic                 reset,

	// APB slave, read only.
	input  logic                 PSEL,
	input  logic                 PENABLE,
	input  logic                 PWRITE,
	input  regFilePkg::apbAddrT  PADDR,
	output regFilePkg::regDataT  PRDATA,
	output logic                 PREADY,
	output logic                 PSLVERR,

	// Inspection read port of the register file.
	output regFilePkg::regAddrT  InspectAddr,
	input  regFilePkg::regDataT  InspectData
);

	import regFilePkg::*;

	apbStateT state;
	logic     setupPhase;

	// Word addressing, the low two bits and bit 7 are ignored.
	assign InspectAddr = PADDR[6:2];

	assign setupPhase = PSEL && !PENABLE;

	// No wait states, every access cycle completes.
	assign PREADY = (state == ApbAccess);

	// **********************************************************************
	// Transfer FSM.
	// **********************************************************************

	always_ff @(posedge Clk) begin
		if (reset) begin
			state   <= ApbIdle;
			PRDATA  <= '0;
			PSLVERR <= 1'b0;
		end else begin
			case (state)
				ApbIdle: begin
					if (setupPhase) begin
						state <= ApbAccess;
						// Writes are refused and leave read data alone.
						PSLVERR <= PWRITE;
						if (!PWRITE) begin
							PRDATA <= InspectData;
						end
					end
				end
				ApbAccess: begin
					state   <= ApbIdle;
					PSLVERR <= 1'b0;
				end
				default: begin
					state   <= ApbIdle;
					PSLVERR <= 1'b0;
				end
			endcase
		end
	end

endmodule

/* design/generalRegFile.sv */
`timescale 1ns/100ps

module generalRegFile (
	input  logic                  Clk,
	input  logic                  reset,

	// Staged write from the write-back stage.
	input  regFilePkg::regAddrT   WriteAddr,
	input  regFilePkg::laneMaskT  WriteLanes,
	input  regFilePkg::regDataT   WriteData,

	input  regFilePkg::regAddrT   ReadAddr [regFilePkg::NumReadPorts],
	output regFilePkg::regDataT   ReadData [regFilePkg::NumReadPorts],

	input  regFilePkg::regAddrT   InspectAddr,
	output regFilePkg::regDataT   InspectData
);

	import regFilePkg::*;

	regDataT regs [NumRegs];

	// **********************************************************************
	// Read path.
	// **********************************************************************

	// Register 0 wins over everything, then the staged write per lane,
	// then storage.
	function automatic regDataT bypassRead(
		input regAddrT  addr,
		input regDataT  stored,
		input regAddrT  wrAddr,
		input laneMaskT wrLanes,
		input regDataT  wrData
	);
		regDataT result;
		result = stored;
		if (addr == '0) begin
			result = '0;
		end else if (addr == wrAddr) begin
			for (int k = 0; k < $bits(laneMaskT); k++) begin
				if (wrLanes[k]) begin
					result[8*k +: 8] = wrData[8*k +: 8];
				end
			end
		end
		return result;
	endfunction

	always_comb begin
		for (int p = 0; p < NumReadPorts; p++) begin
			ReadData[p] = bypassRead(ReadAddr[p], regs[ReadAddr[p]],
				WriteAddr, WriteLanes, WriteData);
		end
	end

	// Debug port sees the same bypassed view as the pipeline.
	always_comb begin
		InspectData = bypassRead(InspectAddr, regs[InspectAddr],
			WriteAddr, WriteLanes, WriteData);
	end

	// **********************************************************************
	// Write path.
	// **********************************************************************

	always_ff @(posedge Clk) begin
		if (reset) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (WriteAddr != '0) begin
			// Only enabled lanes change.
			for (int k = 0; k < $bits(laneMaskT); k++) begin
				if (WriteLanes[k]) begin
					regs[WriteAddr][8*k +: 8] <= WriteData[8*k +: 8];
				end
			end
		end
	end

endmodule

/* design/writeBackAligner.sv */
`timescale 1ns/100ps

module writeBackAligner (
	input  logic                    Clk,
	input  logic                    reset,

	input  logic                    WbValid,
	input  regFilePkg::regAddrT     WbAddr,
	input  regFilePkg::accessSizeT  WbSize,
	input  logic [1:0]              WbOffset,
	input  regFilePkg::regDataT     WbData,

	output regFilePkg::regAddrT     WriteAddr,
	output regFilePkg::laneMaskT    WriteLanes,
	output regFilePkg::regDataT     WriteData
);

	import regFilePkg::*;

	laneMaskT nextLanes;
	regDataT  nextData;

	// **********************************************************************
	// Size and offset decode.
	// **********************************************************************

	// Narrow results are replicated so every lane carries the same bytes.
	always_comb begin
		nextLanes = '0;
		nextData  = WbData;
		case (WbSize)
			SizeByte: begin
				nextLanes = laneMaskT'(1) << WbOffset;
				nextData  = {4{WbData[7:0]}};
			end
			SizeHalf: begin
				// Offset bit 0 plays no part for halfwords.
				nextLanes = WbOffset[1] ? laneMaskT'(4'b1100) : laneMaskT'(4'b0011);
				nextData  = {2{WbData[15:0]}};
			end
			SizeWord: begin
				nextLanes = '1;
			end
			default: begin
				nextLanes = '0;
			end
		endcase
	end

	// **********************************************************************
	// Write-back stage register.
	// **********************************************************************

	always_ff @(posedge Clk) begin
		if (reset) begin
			WriteLanes <= '0;
		end else begin
			WriteLanes <= WbValid ? nextLanes : '0;
		end
	end

	// Address and data only matter where lanes are enabled.
	always_ff @(posedge Clk) begin
		WriteAddr <= WbAddr;
		WriteData <= nextData;
	end

endmodule

/* design/regFilePkg.sv */
package regFilePkg;

	// **********************************************************************
	// Register file widths.
	// **********************************************************************

	// Register number, five bits for 32 registers.
	typedef logic [4:0] regAddrT;

	// Register value.
	typedef logic [31:0] regDataT;

	// Byte-lane enables, bit k covers data bits 8k+7 down to 8k.
	typedef logic [3:0] laneMaskT;

	localparam int NumRegs = 32;

	// Read ports used by the pipeline.
	localparam int NumReadPorts = 4;

	// **********************************************************************
	// Write-back access sizes.
	// **********************************************************************

	typedef logic [1:0] accessSizeT;

	localparam accessSizeT SizeByte = 2'd0;
	localparam accessSizeT SizeHalf = 2'd1;
	localparam accessSizeT SizeWord = 2'd2;

	// **********************************************************************
	// Debug APB port.
	// **********************************************************************

	// Bits 6:2 select the register.
	typedef logic [7:0] apbAddrT;

	typedef enum logic {
		ApbIdle,
		ApbAccess
	} apbStateT;

endpackage
